// ==== Makefile ====
# Verilator simulation of the frame timing core

VERILATOR ?= verilator
TOP       ?= tb_dvbs2_frame
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/dvbs2_cfg_pkg.sv ====
package dvbs2_cfg_pkg;

	//////////////////////////////
	// mode selection types
	//////////////////////////////

	// constellation, same order as the modulator select
	typedef enum logic [1:0] {
		qpsk   = 2'b00,
		psk8   = 2'b01,
		apsk16 = 2'b10,
		apsk32 = 2'b11
	} mod_mode_t;

	// 64800 or 16200 bit fecframe
	typedef enum logic {
		frame_normal = 1'b0,
		frame_short  = 1'b1
	} frame_size_t;

	// ldpc code index
	// 0..10 valid for normal frames, 0..9 for short frames
	typedef logic [3:0] ldpc_code_t;

	// one static mode word, sampled by the table every cycle
	typedef struct packed {
		frame_size_t frame_size;
		logic        pilot_on;
		mod_mode_t   mod_mode;
		ldpc_code_t  ldpc_code;
	} mode_cfg_t;

	//////////////////////////////
	// counts and rates
	//////////////////////////////

	// baud number or clock frequency number, same scale for both
	typedef logic [31:0] rate_num_t;

	// symbol slots within one pl frame, largest is 33282
	typedef logic [15:0] slot_cnt_t;

	// bytes per frame, largest kbch/8 is 7274
	typedef logic [12:0] byte_cnt_t;

	// one transport stream byte
	typedef logic [7:0] ts_byte_t;

	//////////////////////////////
	// frame constants
	//////////////////////////////

	// mpeg-2 ts packet size in bytes
	localparam int ts_pkt_len = 188;

	// first byte of every ts packet
	localparam ts_byte_t ts_sync_byte = 8'h47;

	// bbheader is 80 bits, so ts payload per bbframe is kbch/8 - 10
	localparam byte_cnt_t bb_header_bytes = 13'd10;

endpackage

// ==== hw/dvbs2_frame_pkg.sv ====
package dvbs2_frame_pkg;

	//////////////////////////////
	// scheduler outputs
	//////////////////////////////

	// per-cycle frame strobes from the scheduler
	// frm_head  one pulse at each frame boundary
	// bb_vld    one pulse per bbframe byte slot
	// ts_rd_req one pulse per ts byte to fetch
	typedef struct packed {
		logic frm_head;
		logic bb_vld;
		logic ts_rd_req;
	} frame_flags_t;

	//////////////////////////////
	// stream beat
	//////////////////////////////

	// byte as it leaves the framer
	// syn marks a valid byte, head marks packet byte 0
	typedef struct packed {
		dvbs2_cfg_pkg::ts_byte_t data;
		logic                    syn;
		logic                    head;
	} ts_beat_t;

	// scheduler fsm, idle only until the first length load
	typedef enum logic {
		st_idle = 1'b0,
		st_run  = 1'b1
	} frm_state_t;

endpackage

// ==== hw/dvbs2_frame_top.sv ====
`timescale 1ns/1ns

module dvbs2_frame_top (
	input  logic                         sys_clk,
	input  logic                         glb_rst_n,
	input  dvbs2_cfg_pkg::mode_cfg_t      cfg,
	input  dvbs2_cfg_pkg::rate_num_t      baud_num,
	input  dvbs2_cfg_pkg::rate_num_t      freq_num,
	input  dvbs2_cfg_pkg::ts_byte_t       ts_din,
	output logic                         fs_en,
	output dvbs2_frame_pkg::frame_flags_t flags,
	output dvbs2_frame_pkg::ts_beat_t     ts_out,
	output logic                         sync_err
);

	import dvbs2_cfg_pkg::*;

	// per-mode counts, one cycle behind cfg
	byte_cnt_t kbch_bytes;
	byte_cnt_t ts_bytes;
	slot_cnt_t pl_slots;

	//////////////////////////////
	// symbol slot timing
	//////////////////////////////

	symbol_rate_nco i_symbol_rate_nco (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.baud_num  (baud_num),
		.freq_num  (freq_num),
		.fs_en     (fs_en)
	);

	modcod_table i_modcod_table (
		.sys_clk    (sys_clk),
		.glb_rst_n  (glb_rst_n),
		.cfg        (cfg),
		.kbch_bytes (kbch_bytes),
		.ts_bytes   (ts_bytes),
		.pl_slots   (pl_slots)
	);

	//////////////////////////////
	// frame scheduling and stream
	//////////////////////////////

	frame_sched_ctrl i_frame_sched_ctrl (
		.sys_clk    (sys_clk),
		.glb_rst_n  (glb_rst_n),
		.fs_en      (fs_en),
		.kbch_bytes (kbch_bytes),
		.ts_bytes   (ts_bytes),
		.pl_slots   (pl_slots),
		.flags      (flags)
	);

	// reads only on ts_rd_req, restarts on frm_head
	ts_packet_framer i_ts_packet_framer (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.flags     (flags),
		.ts_din    (ts_din),
		.ts_out    (ts_out),
		.sync_err  (sync_err)
	);

endmodule

// ==== hw/frame_sched_ctrl.sv ====
`timescale 1ns/1ns

module frame_sched_ctrl (
	input  logic                        sys_clk,
	input  logic                        glb_rst_n,
	input  logic                        fs_en,
	input  dvbs2_cfg_pkg::byte_cnt_t     kbch_bytes,
	input  dvbs2_cfg_pkg::byte_cnt_t     ts_bytes,
	input  dvbs2_cfg_pkg::slot_cnt_t     pl_slots,
	output dvbs2_frame_pkg::frame_flags_t flags
);

	import dvbs2_cfg_pkg::*;
	import dvbs2_frame_pkg::*;

	frm_state_t   state;
	// slot index within the current pl frame
	slot_cnt_t    phase;
	slot_cnt_t    phase_inc;
	// lengths of the frame in flight, only change at a boundary
	slot_cnt_t    held_len;
	byte_cnt_t    held_kbch;
	byte_cnt_t    held_ts;
	logic         frame_end;
	logic         load_len;
	logic         step;
	frame_flags_t flags_nxt;

	assign phase_inc = phase + 16'd1;
	// last slot of the frame reached on this strobe
	assign frame_end = (state == st_run) && (phase_inc == held_len);
	// first strobe after reset, or a boundary
	assign load_len  = fs_en && ((state == st_idle) || frame_end);
	// ordinary slot advance inside a frame
	assign step      = fs_en && (state == st_run) && !frame_end;

	//////////////////////////////
	// frame phase and held lengths
	//////////////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			state     <= st_idle;
			phase     <= '0;
			held_len  <= '0;
			held_kbch <= '0;
			held_ts   <= '0;
		end else if (load_len) begin
			// new cfg is picked up here and nowhere else
			state     <= st_run;
			phase     <= '0;
			held_len  <= pl_slots;
			held_kbch <= kbch_bytes;
			held_ts   <= ts_bytes;
		end else if (step) begin
			phase <= phase_inc;
		end
	end

	//////////////////////////////
	// window decode
	//////////////////////////////

	// windows open at slot 1, right after the frame head
	always_comb begin
		flags_nxt.frm_head  = load_len;
		flags_nxt.bb_vld    = step && (phase_inc <= {3'b000, held_kbch});
		flags_nxt.ts_rd_req = step && (phase_inc <= {3'b000, held_ts});
	end

	// all flags one cycle after the strobe
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			flags <= '0;
		end else begin
			flags <= flags_nxt;
		end
	end

	// a zero length from the table would stall the frame forever
	a_len_nonzero: assert property (
		@(posedge sys_clk) disable iff (!glb_rst_n)
		load_len |-> (pl_slots != '0)
	);

endmodule

// ==== hw/modcod_table.sv ====
`timescale 1ns/1ns

module modcod_table (
	input  logic                    sys_clk,
	input  logic                    glb_rst_n,
	input  dvbs2_cfg_pkg::mode_cfg_t cfg,
	output dvbs2_cfg_pkg::byte_cnt_t kbch_bytes,
	output dvbs2_cfg_pkg::byte_cnt_t ts_bytes,
	output dvbs2_cfg_pkg::slot_cnt_t pl_slots
);

	import dvbs2_cfg_pkg::*;

	byte_cnt_t kbch_nxt;
	byte_cnt_t ts_nxt;
	slot_cnt_t slots_nxt;

	//////////////////////////////
	// bbframe size, kbch/8
	//////////////////////////////

	always_comb begin
		case ({cfg.frame_size, cfg.ldpc_code})
			// normal frames, codes 1/4 up to 9/10
			5'h00: kbch_nxt = 13'd2001;
			5'h01: kbch_nxt = 13'd2676;
			5'h02: kbch_nxt = 13'd3216;
			5'h03: kbch_nxt = 13'd4026;
			5'h04: kbch_nxt = 13'd4836;
			5'h05: kbch_nxt = 13'd5380;
			5'h06: kbch_nxt = 13'd6051;
			5'h07: kbch_nxt = 13'd6456;
			5'h08: kbch_nxt = 13'd6730;
			5'h09: kbch_nxt = 13'd7184;
			5'h0a: kbch_nxt = 13'd7274;
			// short frames, no 9/10
			5'h10: kbch_nxt = 13'd384;
			5'h11: kbch_nxt = 13'd654;
			5'h12: kbch_nxt = 13'd789;
			5'h13: kbch_nxt = 13'd879;
			5'h14: kbch_nxt = 13'd1194;
			5'h15: kbch_nxt = 13'd1329;
			5'h16: kbch_nxt = 13'd1464;
			5'h17: kbch_nxt = 13'd1554;
			5'h18: kbch_nxt = 13'd1644;
			5'h19: kbch_nxt = 13'd1779;
			// unsupported code
			default: kbch_nxt = '0;
		endcase
	end

	// payload left after the bbheader, zero for a bad code
	assign ts_nxt = (kbch_nxt != '0) ? (kbch_nxt - bb_header_bytes) : '0;

	//////////////////////////////
	// pl frame length in slots
	//////////////////////////////

	// index is frame size, pilot, modulation
	always_comb begin
		case ({cfg.frame_size, cfg.pilot_on, cfg.mod_mode})
			4'h0: slots_nxt = 16'd32490;
			4'h1: slots_nxt = 16'd21690;
			4'h2: slots_nxt = 16'd16290;
			4'h3: slots_nxt = 16'd13050;
			4'h4: slots_nxt = 16'd33282;
			4'h5: slots_nxt = 16'd22194;
			4'h6: slots_nxt = 16'd16686;
			4'h7: slots_nxt = 16'd13338;
			4'h8: slots_nxt = 16'd8190;
			4'h9: slots_nxt = 16'd5490;
			4'ha: slots_nxt = 16'd4140;
			4'hb: slots_nxt = 16'd3330;
			4'hc: slots_nxt = 16'd8370;
			4'hd: slots_nxt = 16'd5598;
			4'he: slots_nxt = 16'd4212;
			default: slots_nxt = 16'd3402;
		endcase
	end

	// one cycle behind cfg
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			kbch_bytes <= '0;
			ts_bytes   <= '0;
			pl_slots   <= '0;
		end else begin
			kbch_bytes <= kbch_nxt;
			ts_bytes   <= ts_nxt;
			pl_slots   <= slots_nxt;
		end
	end

endmodule

// ==== hw/symbol_rate_nco.sv ====
`timescale 1ns/1ns

module symbol_rate_nco (
	input  logic                    sys_clk,
	input  logic                    glb_rst_n,
	input  dvbs2_cfg_pkg::rate_num_t baud_num,
	input  dvbs2_cfg_pkg::rate_num_t freq_num,
	output logic                    fs_en
);

	import dvbs2_cfg_pkg::*;

	// phase accumulator, always below freq_num
	rate_num_t   acc;
	// one extra bit so the add never wraps
	logic [32:0] acc_sum;
	logic [32:0] acc_wrap;
	logic        acc_ovf;

	assign acc_sum  = {1'b0, acc} + {1'b0, baud_num};
	assign acc_wrap = acc_sum - {1'b0, freq_num};
	// crossing freq_num means one symbol slot has elapsed
	assign acc_ovf  = (acc_sum >= {1'b0, freq_num});

	//////////////////////////////
	// accumulator and strobe
	//////////////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			acc   <= '0;
			fs_en <= 1'b0;
		end else if (acc_ovf) begin
			// keep the remainder, spacing stays even on average
			acc   <= acc_wrap[31:0];
			fs_en <= 1'b1;
		end else begin
			acc   <= acc_sum[31:0];
			fs_en <= 1'b0;
		end
	end

	// rate ratio below one, otherwise strobes would be lost
	a_rate_below_clk: assert property (
		@(posedge sys_clk) disable iff (!glb_rst_n)
		freq_num > baud_num
	);

endmodule

// ==== hw/ts_packet_framer.sv ====
`timescale 1ns/1ns

module ts_packet_framer (
	input  logic                         sys_clk,
	input  logic                         glb_rst_n,
	input  dvbs2_frame_pkg::frame_flags_t flags,
	input  dvbs2_cfg_pkg::ts_byte_t       ts_din,
	output dvbs2_frame_pkg::ts_beat_t     ts_out,
	output logic                         sync_err
);

	import dvbs2_cfg_pkg::*;

	// byte index inside the current 188 byte packet
	logic [7:0] pkt_phase;
	logic       pkt_first;
	logic       pkt_last;
	ts_byte_t   beat_data;
	logic       beat_syn;
	logic       beat_head;

	assign pkt_first = (pkt_phase == 8'd0);
	assign pkt_last  = (pkt_phase == 8'(ts_pkt_len - 1));

	//////////////////////////////
	// packet phase
	//////////////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			pkt_phase <= '0;
		end else if (flags.frm_head) begin
			// each frame starts on a packet boundary
			pkt_phase <= '0;
		end else if (flags.ts_rd_req) begin
			pkt_phase <= pkt_last ? 8'd0 : (pkt_phase + 8'd1);
		end
	end

	//////////////////////////////
	// output beat
	//////////////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			beat_syn  <= 1'b0;
			beat_head <= 1'b0;
		end else begin
			beat_syn  <= flags.ts_rd_req;
			beat_head <= flags.ts_rd_req && pkt_first;
		end
	end

	// byte itself, only meaningful with syn
	always_ff @(posedge sys_clk) begin
		if (flags.ts_rd_req) begin
			beat_data <= ts_din;
		end
	end

	assign ts_out = '{data: beat_data, syn: beat_syn, head: beat_head};

	// sticky, a lost sync byte means the stream is misaligned
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			sync_err <= 1'b0;
		end else if (flags.ts_rd_req && pkt_first && (ts_din != ts_sync_byte)) begin
			sync_err <= 1'b1;
		end
	end

	// a read in a frame head cycle would be lost to the phase restart
	a_no_read_on_head: assert property (
		@(posedge sys_clk) disable iff (!glb_rst_n)
		flags.frm_head |-> !flags.ts_rd_req
	);

endmodule

// ==== list.f ====
+incdir+verif
hw/dvbs2_cfg_pkg.sv
hw/dvbs2_frame_pkg.sv
hw/symbol_rate_nco.sv
hw/modcod_table.sv
hw/frame_sched_ctrl.sv
hw/ts_packet_framer.sv
hw/dvbs2_frame_top.sv
verif/tb_dvbs2_frame.sv

// ==== verif/tb_dvbs2_ref.svh ====
`ifndef TB_DVBS2_REF_SVH
`define TB_DVBS2_REF_SVH

//////////////////////////////
// reference model
//////////////////////////////

// kbch/8 per code, normal frames first then short frames
function automatic byte_cnt_t ref_kbch(mode_cfg_t m);
	int normal_k[11] = '{2001, 2676, 3216, 4026, 4836, 5380, 6051, 6456, 6730, 7184, 7274};
	int short_k[10]  = '{384, 654, 789, 879, 1194, 1329, 1464, 1554, 1644, 1779};
	int code;
	code = int'(m.ldpc_code);
	if (m.frame_size == frame_normal) begin
		return (code < 11) ? byte_cnt_t'(normal_k[code]) : '0;
	end
	return (code < 10) ? byte_cnt_t'(short_k[code]) : '0;
endfunction

// payload after the 10 byte bbheader
function automatic byte_cnt_t ref_ts_bytes(mode_cfg_t m);
	byte_cnt_t k;
	k = ref_kbch(m);
	return (k == '0) ? '0 : byte_cnt_t'(k - 13'd10);
endfunction

// 90 slots per header plus payload slots, 36 pilot slots per 16 slots
function automatic slot_cnt_t ref_pl_slots(mode_cfg_t m);
	int bits;
	int slots;
	int len;
	bits  = (m.frame_size == frame_normal) ? 64800 : 16200;
	slots = bits / ((int'(m.mod_mode) + 2) * 90);
	len   = 90 * (slots + 1);
	if (m.pilot_on) begin
		len = len + ((slots - 1) / 16) * 36;
	end
	return slot_cnt_t'(len);
endfunction

// ideal strobe count after n clocks
function automatic longint ref_strobes(longint n, longint baud, longint freq);
	return (n * baud) / freq;
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_slot(string name, slot_cnt_t exp, slot_cnt_t act);
	if (exp !== act) begin
		$display("FAILED %0t %s expected %0d actual %0d", $time, name, exp, act);
		err_cnt++;
	end
endtask

task automatic check_bytes(string name, byte_cnt_t exp, byte_cnt_t act);
	if (exp !== act) begin
		$display("FAILED %0t %s expected %0d actual %0d", $time, name, exp, act);
		err_cnt++;
	end
endtask

task automatic check_beat(string name, ts_beat_t exp, ts_beat_t act);
	if (exp !== act) begin
		$display("FAILED %0t %s expected %h/%b/%b actual %h/%b/%b", $time, name,
			exp.data, exp.syn, exp.head, act.data, act.syn, act.head);
		err_cnt++;
	end
endtask

task automatic check_bit(string name, logic exp, logic act);
	if (exp !== act) begin
		$display("FAILED %0t %s expected %b actual %b", $time, name, exp, act);
		err_cnt++;
	end
endtask

`endif

// ==== verif/tb_dvbs2_frame.sv ====
`timescale 1ns/1ns

module tb_dvbs2_frame;

	import dvbs2_cfg_pkg::*;
	import dvbs2_frame_pkg::*;

	// modes visited, one per frame
	localparam mode_cfg_t cfg_a = '{frame_short, 1'b0, qpsk, 4'd6};
	localparam mode_cfg_t cfg_b = '{frame_short, 1'b1, qpsk, 4'd6};
	localparam mode_cfg_t cfg_c = '{frame_short, 1'b1, psk8, 4'd9};
	localparam mode_cfg_t cfg_d = '{frame_short, 1'b0, apsk32, 4'd2};
	localparam int baud = 1;
	localparam int freq = 2;
	localparam int strobe_window = 10000;

	logic         sys_clk;
	logic         glb_rst_n;
	mode_cfg_t    cfg;
	rate_num_t    baud_num;
	rate_num_t    freq_num;
	ts_byte_t     ts_din;
	logic         fs_en;
	frame_flags_t flags;
	ts_beat_t     ts_out;
	logic         sync_err;

	int          err_cnt = 0;
	int          other_cnt = 0;
	int          seed = 32'hec2f8e86;
	ts_beat_t    exp_q[$];
	int          heads_seen = 0;
	logic        bad_req = 1'b0;
	logic        sync_seen = 1'b0;

	`include "tb_dvbs2_ref.svh"

	dvbs2_frame_top i_dvbs2_frame_top (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.cfg       (cfg),
		.baud_num  (baud_num),
		.freq_num  (freq_num),
		.ts_din    (ts_din),
		.fs_en     (fs_en),
		.flags     (flags),
		.ts_out    (ts_out),
		.sync_err  (sync_err)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	//////////////////////////////
	// sequence
	//////////////////////////////

	initial begin
		glb_rst_n = 1'b0;
		cfg       = cfg_a;
		baud_num  = rate_num_t'(baud);
		freq_num  = rate_num_t'(freq);
		repeat (3) @(negedge sys_clk);
		glb_rst_n = 1'b1;
		// each cfg change lands mid frame
		wait (heads_seen >= 1);
		repeat (100) @(negedge sys_clk);
		cfg = cfg_b;
		wait (heads_seen >= 2);
		repeat (100) @(negedge sys_clk);
		cfg = cfg_c;
		wait (heads_seen >= 3);
		repeat (100) @(negedge sys_clk);
		cfg = cfg_d;
		wait (heads_seen >= 4);
		repeat (100) @(negedge sys_clk);
		bad_req = 1'b1;
		wait (heads_seen >= 5);
		@(negedge sys_clk);
		// second reset must clear the sticky error
		glb_rst_n = 1'b0;
		repeat (3) @(negedge sys_clk);
		glb_rst_n = 1'b1;
		repeat (2) @(negedge sys_clk);
		if (!sync_seen) begin
			$display("sync_err never rose after the bad head byte");
			other_cnt++;
		end
		$display("errors: %0d value, %0d other", err_cnt, other_cnt);
		if (err_cnt == 0 && other_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	//////////////////////////////
	// ts byte source
	//////////////////////////////

	initial begin
		int       pkt_idx;
		logic     bad_done;
		ts_byte_t nxt;
		ts_din   = '0;
		pkt_idx  = 0;
		bad_done = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (!glb_rst_n) begin
				pkt_idx = 0;
			end else begin
				if (flags.frm_head) begin
					pkt_idx = 0;
				end
				if (flags.ts_rd_req) begin
					if (pkt_idx == 0 && bad_req && !bad_done) begin
						nxt      = 8'h12;
						bad_done = 1'b1;
					end else if (pkt_idx == 0) begin
						nxt = ts_sync_byte;
					end else begin
						nxt = ts_byte_t'($random(seed));
					end
					ts_din = nxt;
					exp_q.push_back('{data: nxt, syn: 1'b1, head: (pkt_idx == 0)});
					pkt_idx = (pkt_idx == ts_pkt_len - 1) ? 0 : pkt_idx + 1;
				end
			end
		end
	end

	//////////////////////////////
	// compare process
	//////////////////////////////

	// sampled at posedge, values of the cycle just ending
	always @(posedge sys_clk) begin
		int        cycles;
		longint    fs_total;
		int        fs_cnt;
		int        bb_cnt;
		int        ts_cnt;
		logic      exp_sync;
		mode_cfg_t frm_cfg;
		ts_beat_t  exp;
		if (!glb_rst_n) begin
			check_bit("fs_en", 1'b0, fs_en);
			check_bit("flags.frm_head", 1'b0, flags.frm_head);
			check_bit("flags.bb_vld", 1'b0, flags.bb_vld);
			check_bit("flags.ts_rd_req", 1'b0, flags.ts_rd_req);
			check_bit("ts_out.syn", 1'b0, ts_out.syn);
			check_bit("ts_out.head", 1'b0, ts_out.head);
			check_bit("sync_err", 1'b0, sync_err);
			cycles   = 0;
			fs_total = 0;
			fs_cnt   = 0;
			bb_cnt   = 0;
			ts_cnt   = 0;
			exp_sync = 1'b0;
			exp_q.delete();
		end else begin
			cycles++;
			if (cycles == 1) begin
				check_bit("state idle", 1'b1,
					i_dvbs2_frame_top.i_frame_sched_ctrl.state == st_idle);
			end
			if (fs_en && cycles <= strobe_window) begin
				fs_total++;
			end
			if (cycles == strobe_window) begin
				if (fs_total > ref_strobes(strobe_window, baud, freq) + 1 ||
						fs_total + 1 < ref_strobes(strobe_window, baud, freq)) begin
					$display("strobe count %0d too far from the ideal rate", fs_total);
					other_cnt++;
				end
			end
			// close the frame that just ended
			if (flags.frm_head) begin
				if (heads_seen > 0) begin
					check_slot("fs_en per frame", ref_pl_slots(frm_cfg), slot_cnt_t'(fs_cnt));
					check_bytes("bb_vld per frame", ref_kbch(frm_cfg), byte_cnt_t'(bb_cnt));
					check_bytes("ts_rd_req per frame", ref_ts_bytes(frm_cfg),
						byte_cnt_t'(ts_cnt));
				end
				heads_seen++;
				frm_cfg = cfg;
				fs_cnt  = 0;
				bb_cnt  = 0;
				ts_cnt  = 0;
			end
			fs_cnt += int'(fs_en);
			bb_cnt += int'(flags.bb_vld);
			ts_cnt += int'(flags.ts_rd_req);
			if (ts_out.syn) begin
				if (exp_q.size() == 0) begin
					$display("ts_out beat at %0t with no byte read", $time);
					other_cnt++;
				end else begin
					exp = exp_q.pop_front();
					check_beat("ts_out", exp, ts_out);
					if (exp.head && exp.data != ts_sync_byte) begin
						exp_sync = 1'b1;
					end
				end
			end else begin
				check_bit("ts_out.head", 1'b0, ts_out.head);
			end
			check_bit("sync_err", exp_sync, sync_err);
			if (sync_err) begin
				sync_seen = 1'b1;
			end
		end
	end

	//////////////////////////////
	// watchdog
	//////////////////////////////

	initial begin
		longint limit;
		limit = (longint'(ref_pl_slots(cfg_a)) + ref_pl_slots(cfg_b) +
			ref_pl_slots(cfg_c) + ref_pl_slots(cfg_d)) * freq / baud + 20000;
		repeat (limit) @(posedge sys_clk);
		$display("run did not finish within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

endmodule
